// File: Makefile
# Verilator flow for the SDRAM controller

VERILATOR  ?= verilator
TOP        ?= tbSdram
RTL_TOP    ?= sdram
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= TEST PASSED
VFLAGS     ?= --binary --timing --assert -j 0 --timescale 1ns/100ps
LINT_FLAGS ?= --timing --assert --timescale 1ns/100ps

SRCS     := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(filter source/%,$(SRCS))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: list.f
source/sdramPkg.sv
source/fifoSync.sv
source/sdramArb.sv
source/sdramIo.sv
source/sdram.sv
sim/sdramModel.sv
sim/tbSdram.sv

// File: sim/sdramModel.sv
`timescale 1ns/100ps
`default_nettype none

module sdramModel
    import sdramPkg::*;
#(
    parameter int tRCD = 3,
    parameter int tRC  = 9,
    parameter int CAS  = 3
) (
    input  logic              clk,
    input  logic              rstN,               // Held while the controller is in reset
    input  logic              csN,
    input  logic              rasN,
    input  logic              casN,
    input  logic              weN,
    input  logic [BANK_W-1:0] ba,
    input  logic [ROW_W-1:0]  addr,
    input  logic [1:0]        dqm,
    input  data_t             dq,
    input  logic              ctrlOe,
    output data_t             dqOut,
    output logic              dqOe,
    output int                refreshCount,
    output int                violations,
    output logic              initOk
);

    data_t            mem [addr_t];
    logic [ROW_W-1:0] openRow [4];
    logic [3:0]       rowOpen;
    int               lastAct [4];
    int               cycle;
    int               initStep;
    data_t            pipeData [CAS];
    logic [CAS-1:0]   pipeValid;
    dramCmd_t         cmd;

    assign cmd   = dramCmd_t'({csN, rasN, casN, weN});
    assign dqOut = pipeData[CAS-1];
    assign dqOe  = pipeValid[CAS-1];   // Word sits on DQ for the edge CAS cycles after READ

    task automatic violation(input string msg);
        violations++;
        $display("Model violation at %0t: %s", $time, msg);
    endtask

    // Power-up order is precharge-all, two refreshes, then the mode register
    function automatic logic initStepOk(int step, dramCmd_t c, logic [ROW_W-1:0] a);
        case (step)
            0:       return c == PRECHARGE && a[10];
            1, 2:    return c == REFRESH;
            default: return c == LOAD_MODE && a[6:4] == 3'(CAS) && a[2:0] == 3'b000;
        endcase
    endfunction

    always @(posedge clk) begin
        addr_t full;
        logic  isRead;
        data_t rdWord;
        if (!rstN) begin
            rowOpen      = '0;
            cycle        = 0;
            initStep     = 0;
            refreshCount = 0;
            violations   = 0;
            initOk       = 1'b0;
            for (int b = 0; b < 4; b++) lastAct[b] = -1000;
            pipeValid <= '0;
        end else begin
            cycle++;
            isRead = 1'b0;
            rdWord = '0;
            if (ctrlOe && dqOe) violation("controller and device drive DQ at the same time");
            if (initStep < 4 && cmd != NOP) begin
                if (initStepOk(initStep, cmd, addr)) begin
                    initStep++;
                end else begin
                    violation($sformatf("power-up step %0d got command %s", initStep, cmd.name()));
                    initStep = 5;
                end
                initOk = initStep == 4;
            end

            // --------------------------------------------------------------------
            // Command decode

            case (cmd)
                ACTIVE: begin
                    if (rowOpen[ba]) violation($sformatf("ACTIVE on open bank %0d", ba));
                    if (cycle - lastAct[ba] < tRC)
                        violation($sformatf("ACTIVE to ACTIVE on bank %0d after %0d cycles",
                                            ba, cycle - lastAct[ba]));
                    rowOpen[ba] = 1'b1;
                    openRow[ba] = addr;
                    lastAct[ba] = cycle;
                end
                READ, WRITE: begin
                    if (!rowOpen[ba])
                        violation($sformatf("%s to closed bank %0d", cmd.name(), ba));
                    else if (cycle - lastAct[ba] < tRCD)
                        violation($sformatf("%s on bank %0d only %0d cycles after ACTIVE",
                                            cmd.name(), ba, cycle - lastAct[ba]));
                    if (dqm != 2'b00)
                        violation($sformatf("%s with data mask %b set", cmd.name(), dqm));
                    full = {ba, openRow[ba], addr[COL_W-1:0]};
                    if (cmd == WRITE) begin
                        if (!ctrlOe) violation("WRITE without data driven on DQ");
                        mem[full] = dq;
                    end else begin
                        isRead = 1'b1;
                        rdWord = mem.exists(full) ? mem[full] : '0;
                    end
                    if (addr[10]) rowOpen[ba] = 1'b0;   // Auto-precharge
                end
                PRECHARGE: begin
                    if (addr[10]) rowOpen = '0;
                    else rowOpen[ba] = 1'b0;
                end
                REFRESH: begin
                    refreshCount++;
                    if (rowOpen != '0) violation("REFRESH while a bank is open");
                end
                default: ;
            endcase

            pipeValid   <= {pipeValid[CAS-2:0], isRead};
            pipeData[0] <= rdWord;
            for (int i = 1; i < CAS; i++) pipeData[i] <= pipeData[i-1];
        end
    end

endmodule

`default_nettype wire

// File: sim/tbSdram.sv
`timescale 1ns/100ps
`default_nettype none

module tbSdram
    import sdramPkg::*;
();

    localparam int tRC        = 9;
    localparam int tRCD       = 3;
    localparam int tINIT      = 20;
    localparam int tREF       = 80;
    localparam int CAS        = 3;
    localparam int NUM_RANDOM = 40;
    localparam int ACC_CYCLES = tRCD + tRC;   // Upper bound on the cycles of one access

    typedef struct packed {
        logic  sync;                          // Issued in the same cycle as the entry before
        tag_t  src;
        logic  write;
        addr_t addr;
        data_t data;
    } stim_t;

    logic               clk;
    logic               rstN;
    logic               initDone;
    logic [NUM_SRC-1:0] srcReq;
    logic [NUM_SRC-1:0] srcWrite;
    addr_t              srcAddr [NUM_SRC];
    data_t              srcWrData [NUM_SRC];
    logic [NUM_SRC-1:0] srcAck;
    logic [NUM_SRC-1:0] srcRdValid;
    data_t              srcRdData;
    data_t              dqBus;
    data_t              dramDqOut;
    logic               dramDqOe;
    logic [ROW_W-1:0]   dramAddr;
    logic [BANK_W-1:0]  dramBa;
    logic [1:0]         dramDqm;
    logic               dramCke;
    logic               dramCsN;
    logic               dramRasN;
    logic               dramCasN;
    logic               dramWeN;
    data_t              modelDq;
    logic               modelOe;
    int                 refreshCount;
    int                 violations;
    logic               initOk;

    stim_t       stimTable [$];
    data_t       refMem [addr_t];
    data_t       expQ [NUM_SRC][$];
    logic [15:0] lfsr            = 16'd18853;
    int          cycle           = 0;
    int          cycleLimit      = 1 << 30;
    int          cyclesAfterInit = 0;
    int          mismatches      = 0;
    int          otherErrors     = 0;

    assign dqBus = dramDqOe ? dramDqOut : (modelOe ? modelDq : 16'hDEAD);

    sdram #(
        .tRC   (tRC),
        .tRCD  (tRCD),
        .tINIT (tINIT),
        .tREF  (tREF),
        .CAS   (CAS)
    ) DUT (
        .clk        (clk),        .rstN       (rstN),       .initDone   (initDone),
        .srcReq     (srcReq),     .srcWrite   (srcWrite),   .srcAddr    (srcAddr),
        .srcWrData  (srcWrData),  .srcAck     (srcAck),     .srcRdValid (srcRdValid),
        .srcRdData  (srcRdData),  .dramDqIn   (dqBus),      .dramDqOut  (dramDqOut),
        .dramDqOe   (dramDqOe),   .dramAddr   (dramAddr),   .dramBa     (dramBa),
        .dramDqm    (dramDqm),    .dramCke    (dramCke),    .dramCsN    (dramCsN),
        .dramRasN   (dramRasN),   .dramCasN   (dramCasN),   .dramWeN    (dramWeN)
    );

    sdramModel #(
        .tRCD (tRCD),
        .tRC  (tRC),
        .CAS  (CAS)
    ) device (
        .clk  (clk),       .rstN (rstN),      .csN          (dramCsN),
        .rasN (dramRasN),  .casN (dramCasN),  .weN          (dramWeN),
        .ba   (dramBa),    .addr (dramAddr),  .dq           (dqBus),
        .dqm  (dramDqm),
        .ctrlOe (dramDqOe), .dqOut (modelDq), .dqOe         (modelOe),
        .refreshCount (refreshCount), .violations (violations), .initOk (initOk)
    );

    always #2 clk = ~clk;

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11, stepped once per bit
    function automatic logic [31:0] takeBits(int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic data_t refRead(addr_t a);
        return refMem.exists(a) ? refMem[a] : '0;
    endfunction

    task automatic addEntry(logic sync, tag_t src, logic write, addr_t addr, data_t data);
        stimTable.push_back('{sync: sync, src: src, write: write, addr: addr, data: data});
    endtask

    task automatic buildTable();
        tag_t       src;
        logic       wr;
        logic [1:0] rowBits;
        logic [2:0] colBits;
        data_t      d;
        addEntry(1'b0, 1'b0, 1'b1, 24'h012345, 16'hA5C3);
        addEntry(1'b0, 1'b0, 1'b0, 24'h012345, 16'h0000);
        addEntry(1'b0, 1'b0, 1'b0, 24'h3FFFFF, 16'h0000);   // Never written
        addEntry(1'b0, 1'b0, 1'b1, 24'h800010, 16'hBEEF);
        addEntry(1'b1, 1'b1, 1'b1, 24'hC00020, 16'h5A5A);
        addEntry(1'b0, 1'b0, 1'b0, 24'hC00020, 16'h0000);
        addEntry(1'b1, 1'b1, 1'b0, 24'h800010, 16'h0000);
        // Small row and column range so that random reads hit earlier writes
        for (int i = 0; i < NUM_RANDOM; i++) begin
            src     = tag_t'(takeBits(1));
            wr      = 1'(takeBits(1));
            rowBits = 2'(takeBits(2));
            colBits = 3'(takeBits(3));
            d       = data_t'(takeBits(16));
            addEntry(1'b0, src, wr, {2'(i), 11'b0, rowBits, 6'b0, colBits}, d);
        end
    endtask

    task automatic issueRequest(input stim_t st, output int ackAt);
        srcReq[st.src]    = 1'b1;
        srcWrite[st.src]  = st.write;
        srcAddr[st.src]   = st.addr;
        srcWrData[st.src] = st.data;
        do begin
            tick();
        end while (!srcAck[st.src]);
        ackAt          = cycle;
        srcReq[st.src] = 1'b0;
        // Commands reach the device in ack order
        if (st.write) refMem[st.addr] = st.data;
        else expQ[st.src].push_back(refRead(st.addr));
    endtask

    // ------------------------------------------------------------------------
    // Monitor and watchdog

    always begin
        data_t expData;
        tick();
        cycle++;
        if (initDone) cyclesAfterInit++;
        if (!initDone && srcAck != '0) begin
            otherErrors++;
            $display("Source acked before init finished at %0t", $time);
        end
        for (int s = 0; s < NUM_SRC; s++) begin
            if (srcRdValid[s] && expQ[s].size() == 0) begin
                otherErrors++;
                $display("Read data on source %0d with no read pending at %0t", s, $time);
            end else if (srcRdValid[s]) begin
                expData = expQ[s].pop_front();
                if (srcRdData != expData) begin
                    mismatches++;
                    $display("MISMATCH at %0t: source %0d read %h, expected %h",
                             $time, s, srcRdData, expData);
                end
            end
        end
    end

    initial begin
        while (cycle < cycleLimit) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", cycleLimit);
        $display("TEST FAILED");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Stimulus

    initial begin
        int ackA;
        int ackB;
        int idx;
        clk      = 1'b0;
        rstN     = 1'b0;
        srcReq   = '0;
        srcWrite = '0;
        for (int s = 0; s < NUM_SRC; s++) begin
            srcAddr[s]   = '0;
            srcWrData[s] = '0;
        end
        buildTable();
        cycleLimit = 20 * stimTable.size() * ACC_CYCLES + tINIT;

        repeat (4) @(posedge clk);
        #1;
        if (initDone || srcAck != '0 || srcRdValid != '0 || dramDqOe || !dramCke ||
            {dramCsN, dramRasN, dramCasN, dramWeN} != NOP) begin
            mismatches++;
            $display("MISMATCH at %0t: outputs not in their reset state", $time);
        end
        rstN = 1'b1;
        while (!initDone) tick();

        idx = 0;
        while (idx < stimTable.size()) begin
            if (idx + 1 < stimTable.size() && stimTable[idx+1].sync) begin
                fork
                    issueRequest(stimTable[idx], ackA);
                    issueRequest(stimTable[idx+1], ackB);
                join
                if ((stimTable[idx].src < stimTable[idx+1].src) != (ackA < ackB)) begin
                    otherErrors++;
                    $display("Lower source was not acked first at %0t", $time);
                end
                idx += 2;
            end else begin
                issueRequest(stimTable[idx], ackA);
                idx++;
            end
        end

        while (expQ[0].size() + expQ[1].size() != 0) tick();
        repeat (4 * tREF) tick();   // Idle long enough for several refresh periods

        if (!initOk) begin
            otherErrors++;
            $display("Device did not see the power-up command order");
        end
        if (refreshCount - 2 < cyclesAfterInit / tREF - 1) begin
            otherErrors++;
            $display("Only %0d refreshes in %0d cycles after init",
                     refreshCount - 2, cyclesAfterInit);
        end

        $display("Error counts: %0d mismatches, %0d other errors, %0d model violations",
                 mismatches, otherErrors, violations);
        if (mismatches == 0 && otherErrors == 0 && violations == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/fifoSync.sv
`timescale 1ns/100ps
`default_nettype none

module fifoSync #(
    parameter int WIDTH      = 8,
    parameter int DEPTH_LOG2 = 2
) (
    input  logic             clk,
    input  logic             rstN,

    input  logic [WIDTH-1:0] writeData,
    input  logic             writeReq,
    output logic             writeAck,

    output logic [WIDTH-1:0] readData,
    output logic             readReq,
    input  logic             readAck
);

    localparam int DEPTH = 2 ** DEPTH_LOG2;

    logic [WIDTH-1:0]      mem [DEPTH];
    logic [DEPTH_LOG2-1:0] wrPtr;
    logic [DEPTH_LOG2-1:0] rdPtr;
    logic [DEPTH_LOG2:0]   count;
    logic                  wrEn;
    logic                  rdEn;

    assign writeAck = count != (DEPTH_LOG2 + 1)'(DEPTH);   // Not full
    assign readReq  = count != '0;                         // Not empty
    assign wrEn     = writeReq && writeAck;
    assign rdEn     = readReq && readAck;
    assign readData = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrPtr] <= writeData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (wrEn) wrPtr <= wrPtr + 1'b1;
            if (rdEn) rdPtr <= rdPtr + 1'b1;
            case ({wrEn, rdEn})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The writer only pushes when it reserved space a cycle earlier
    assert property (@(posedge clk) disable iff (!rstN) writeReq |-> writeAck)
        else $error("Write into a full FIFO");

    // The reader only takes an entry that it was offered
    assert property (@(posedge clk) disable iff (!rstN) readAck |-> readReq)
        else $error("Read from an empty FIFO");

endmodule

`default_nettype wire

// File: source/sdram.sv
`timescale 1ns/100ps
`default_nettype none

module sdram
    import sdramPkg::*;
#(
    parameter int tRC        = 9,
    parameter int tRAS       = 6,
    parameter int tRP        = 3,
    parameter int tRCD       = 3,
    parameter int tMRD       = 2,
    parameter int tDPL       = 2,
    parameter int tINIT      = 14250,
    parameter int tREF       = 1114,
    parameter int CAS        = 3,
    parameter int DEPTH_LOG2 = 2
) (
    input  logic               clk,
    input  logic               rstN,
    output logic               initDone,

    input  logic [NUM_SRC-1:0] srcReq,
    input  logic [NUM_SRC-1:0] srcWrite,
    input  addr_t              srcAddr [NUM_SRC],
    input  data_t              srcWrData [NUM_SRC],
    output logic [NUM_SRC-1:0] srcAck,
    output logic [NUM_SRC-1:0] srcRdValid,
    output data_t              srcRdData,

    input  data_t              dramDqIn,
    output data_t              dramDqOut,
    output logic               dramDqOe,
    output logic [ROW_W-1:0]   dramAddr,
    output logic [BANK_W-1:0]  dramBa,
    output logic [1:0]         dramDqm,
    output logic               dramCke,
    output logic               dramCsN,
    output logic               dramRasN,
    output logic               dramCasN,
    output logic               dramWeN
);

    cmd_t  arbCmdData;
    logic  arbCmdReq;
    logic  arbCmdAck;
    cmd_t  ioCmdData;
    logic  ioCmdReq;
    logic  ioCmdAck;
    logic  rdValid;
    tag_t  rdTag;
    data_t rdData;

    sdramArb #(
        .NSRC (NUM_SRC)
    ) arb (
        .clk        (clk),
        .rstN       (rstN),
        .srcReq     (srcReq),
        .srcWrite   (srcWrite),
        .srcAddr    (srcAddr),
        .srcWrData  (srcWrData),
        .srcAck     (srcAck),
        .srcRdValid (srcRdValid),
        .srcRdData  (srcRdData),
        .cmdData    (arbCmdData),
        .cmdReq     (arbCmdReq),
        .cmdAck     (arbCmdAck),
        .rdValid    (rdValid),
        .rdTag      (rdTag),
        .rdData     (rdData)
    );

    // Absorbs requests while the sequencer is busy with init or refresh
    fifoSync #(
        .WIDTH      ($bits(cmd_t)),
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) cmdFifo (
        .clk       (clk),
        .rstN      (rstN),
        .writeData (arbCmdData),
        .writeReq  (arbCmdReq),
        .writeAck  (arbCmdAck),
        .readData  (ioCmdData),
        .readReq   (ioCmdReq),
        .readAck   (ioCmdAck)
    );

    sdramIo #(
        .tRC   (tRC),
        .tRAS  (tRAS),
        .tRP   (tRP),
        .tRCD  (tRCD),
        .tMRD  (tMRD),
        .tDPL  (tDPL),
        .tINIT (tINIT),
        .tREF  (tREF),
        .CAS   (CAS)
    ) io (
        .clk       (clk),
        .rstN      (rstN),
        .initDone  (initDone),
        .cmdData   (ioCmdData),
        .cmdReq    (ioCmdReq),
        .cmdAck    (ioCmdAck),
        .rdValid   (rdValid),
        .rdTag     (rdTag),
        .rdData    (rdData),
        .dramDqIn  (dramDqIn),
        .dramDqOut (dramDqOut),
        .dramDqOe  (dramDqOe),
        .dramAddr  (dramAddr),
        .dramBa    (dramBa),
        .dramDqm   (dramDqm),
        .dramCke   (dramCke),
        .dramCsN   (dramCsN),
        .dramRasN  (dramRasN),
        .dramCasN  (dramCasN),
        .dramWeN   (dramWeN)
    );

endmodule

`default_nettype wire

// File: source/sdramArb.sv
`timescale 1ns/100ps
`default_nettype none

module sdramArb
    import sdramPkg::*;
#(
    parameter int NSRC = NUM_SRC
) (
    input  logic            clk,
    input  logic            rstN,

    input  logic [NSRC-1:0] srcReq,
    input  logic [NSRC-1:0] srcWrite,
    input  addr_t           srcAddr [NSRC],
    input  data_t           srcWrData [NSRC],
    output logic [NSRC-1:0] srcAck,
    output logic [NSRC-1:0] srcRdValid,
    output data_t           srcRdData,

    output cmd_t            cmdData,
    output logic            cmdReq,
    input  logic            cmdAck,

    input  logic            rdValid,
    input  tag_t            rdTag,
    input  data_t           rdData
);

    logic grantAny;
    tag_t grantIdx;
    logic grant;

    // Lowest index wins, so scan downwards and let later hits overwrite
    always_comb begin
        grantAny = 1'b0;
        grantIdx = '0;
        for (int s = NSRC - 1; s >= 0; s--) begin
            if (srcReq[s]) begin
                grantAny = 1'b1;
                grantIdx = tag_t'(s);
            end
        end
    end

    // No grant while a push is in flight, the FIFO space flag lags by one
    assign grant = grantAny && cmdAck && !cmdReq;

    // ------------------------------------------------------------------------
    // Command side

    always_ff @(posedge clk) begin
        if (!rstN) begin
            srcAck <= '0;
            cmdReq <= 1'b0;
        end else begin
            srcAck <= '0;
            cmdReq <= grant;                      // Push lines up with the ack
            if (grant) srcAck[grantIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            cmdData <= '{write: srcWrite[grantIdx],
                         tag:   grantIdx,
                         addr:  srcAddr[grantIdx],
                         data:  srcWrData[grantIdx]};
        end
    end

    // ------------------------------------------------------------------------
    // Read return

    always_ff @(posedge clk) begin
        if (!rstN) begin
            srcRdValid <= '0;
        end else begin
            for (int s = 0; s < NSRC; s++) begin
                srcRdValid[s] <= rdValid && (rdTag == tag_t'(s));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdValid) srcRdData <= rdData;
    end

    // One source at a time, and never two acks in consecutive cycles
    assert property (@(posedge clk) disable iff (!rstN)
        (srcAck != '0) |-> $onehot(srcAck) ##1 (srcAck == '0))
        else $error("Overlapping or back-to-back source acks");

endmodule

`default_nettype wire

// File: source/sdramIo.sv
`timescale 1ns/100ps
`default_nettype none

module sdramIo
    import sdramPkg::*;
#(
    parameter int tRC   = 9,
    parameter int tRAS  = 6,
    parameter int tRP   = 3,
    parameter int tRCD  = 3,
    parameter int tMRD  = 2,
    parameter int tDPL  = 2,
    parameter int tINIT = 14250,
    parameter int tREF  = 1114,
    parameter int CAS   = 3
) (
    input  logic              clk,
    input  logic              rstN,
    output logic              initDone,

    input  cmd_t              cmdData,
    input  logic              cmdReq,
    output logic              cmdAck,

    output logic              rdValid,
    output tag_t              rdTag,
    output data_t             rdData,

    input  data_t             dramDqIn,
    output data_t             dramDqOut,
    output logic              dramDqOe,
    output logic [ROW_W-1:0]  dramAddr,
    output logic [BANK_W-1:0] dramBa,
    output logic [1:0]        dramDqm,
    output logic              dramCke,
    output logic              dramCsN,
    output logic              dramRasN,
    output logic              dramCasN,
    output logic              dramWeN
);

    function automatic int maxOf(int a, int b);
        return (a > b) ? a : b;
    endfunction

    // Spacing from READ or WRITE to the next command, auto-precharge included
    localparam int WAIT_WR = maxOf(maxOf(tDPL, tRAS - tRCD) + tRP, tRC - tRCD);
    localparam int WAIT_RD = maxOf(maxOf(maxOf(1, tRAS - tRCD) + tRP, tRC - tRCD), CAS + 1);
    localparam int WAIT_W  = $clog2(maxOf(tINIT, maxOf(tRC, WAIT_RD)) + 1);
    localparam int REF_W   = $clog2(tREF + 1);

    localparam logic [ROW_W-1:0] AP_BIT    = ROW_W'(1 << 10);  // A10
    // Burst length 1, sequential, CAS latency in A6..A4
    localparam logic [ROW_W-1:0] MODE_WORD = {6'b0, 3'(CAS), 1'b0, 3'b000};

    typedef logic [WAIT_W-1:0] wait_t;

    function automatic wait_t waitLoad(int n);
        return (n > 1) ? wait_t'(n - 1) : '0;
    endfunction

    ioState_t         state;
    wait_t            waitCnt;
    logic [REF_W-1:0] refCnt;
    logic             refDue;
    logic             refStart;
    cmd_t             cmdReg;
    dramCmd_t         dramCmd;
    logic [CAS-1:0]   rdPipeValid;
    tag_t             rdPipeTag [CAS];

    assign {dramCsN, dramRasN, dramCasN, dramWeN} = dramCmd;
    assign dramCke  = 1'b1;                 // No power-down or self-refresh
    assign refStart = (state == ST_IDLE) && (waitCnt == '0) && refDue;
    assign cmdAck   = (state == ST_IDLE) && (waitCnt == '0) && !refDue && cmdReq;

    // ------------------------------------------------------------------------
    // Sequencer

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state    <= ST_INIT;
            waitCnt  <= waitLoad(tINIT);
            initDone <= 1'b0;
            dramCmd  <= NOP;
            dramDqOe <= 1'b0;
            dramDqm  <= 2'b11;
        end else begin
            dramCmd  <= NOP;
            dramDqOe <= 1'b0;
            if (waitCnt != '0) begin
                waitCnt <= waitCnt - 1'b1;
            end else begin
                case (state)
                    ST_INIT: begin
                        dramCmd  <= PRECHARGE;
                        dramAddr <= AP_BIT;             // All banks
                        waitCnt  <= waitLoad(tRP);
                        state    <= ST_REF1;
                    end
                    ST_REF1, ST_REF2: begin
                        dramCmd <= REFRESH;
                        waitCnt <= waitLoad(tRC);
                        state   <= (state == ST_REF1) ? ST_REF2 : ST_MODE;
                    end
                    ST_MODE: begin
                        dramCmd  <= LOAD_MODE;
                        dramBa   <= '0;
                        dramAddr <= MODE_WORD;
                        dramDqm  <= 2'b00;
                        waitCnt  <= waitLoad(tMRD);
                        initDone <= 1'b1;
                        state    <= ST_IDLE;
                    end
                    ST_IDLE: begin
                        if (refDue) begin
                            dramCmd <= REFRESH;
                            waitCnt <= waitLoad(tRC);
                        end else if (cmdReq) begin
                            dramCmd  <= ACTIVE;
                            dramBa   <= cmdData.addr[COL_W+ROW_W +: BANK_W];
                            dramAddr <= cmdData.addr[COL_W +: ROW_W];
                            cmdReg   <= cmdData;
                            waitCnt  <= waitLoad(tRCD);
                            state    <= ST_ACCESS;
                        end
                    end
                    ST_ACCESS: begin
                        dramCmd   <= cmdReg.write ? WRITE : READ;
                        dramAddr  <= ROW_W'(cmdReg.addr[COL_W-1:0]) | AP_BIT;
                        dramDqOut <= cmdReg.data;
                        dramDqOe  <= cmdReg.write;
                        waitCnt   <= waitLoad(cmdReg.write ? WAIT_WR : WAIT_RD);
                        state     <= ST_IDLE;
                    end
                    default: state <= ST_INIT;
                endcase
            end
        end
    end

    // Refresh interval counter, running once the device is set up
    always_ff @(posedge clk) begin
        if (!rstN) begin
            refCnt <= REF_W'(tREF - 1);
            refDue <= 1'b0;
        end else if (initDone) begin
            if (refStart) refDue <= 1'b0;
            if (refCnt == '0) begin
                refCnt <= REF_W'(tREF - 1);
                refDue <= 1'b1;
            end else begin
                refCnt <= refCnt - 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Read data capture

    always_ff @(posedge clk) begin
        if (!rstN) begin
            rdPipeValid <= '0;
            rdValid     <= 1'b0;
        end else begin
            rdPipeValid <= {rdPipeValid[CAS-2:0], dramCmd == READ};
            rdValid     <= rdPipeValid[CAS-1];
        end
    end

    always_ff @(posedge clk) begin
        rdPipeTag[0] <= cmdReg.tag;
        for (int i = 1; i < CAS; i++) begin
            rdPipeTag[i] <= rdPipeTag[i-1];
        end
        if (rdPipeValid[CAS-1]) begin
            rdTag  <= rdPipeTag[CAS-1];
            rdData <= dramDqIn;                 // Device drives this cycle
        end
    end

    // The controller must not drive DQ while a read word is on its way back
    assert property (@(posedge clk) disable iff (!rstN) (rdPipeValid != '0) |-> !dramDqOe)
        else $error("DQ driven inside a read CAS window");

endmodule

`default_nettype wire

// File: source/sdramPkg.sv
`default_nettype none

package sdramPkg;

    localparam int NUM_SRC = 2;
    localparam int DATA_W  = 16;
    localparam int BANK_W  = 2;
    localparam int ROW_W   = 13;
    localparam int COL_W   = 9;

    typedef logic [DATA_W-1:0]              data_t;
    typedef logic [BANK_W+ROW_W+COL_W-1:0]  addr_t;   // {bank, row, column}
    typedef logic [$clog2(NUM_SRC)-1:0]     tag_t;    // Index of the issuing source

    typedef struct packed {
        logic  write;
        tag_t  tag;
        addr_t addr;
        data_t data;
    } cmd_t;

    // Pin command as {CS_N, RAS_N, CAS_N, WE_N}
    typedef enum logic [3:0] {
        NOP       = 4'b0111,
        ACTIVE    = 4'b0011,
        READ      = 4'b0101,
        WRITE     = 4'b0100,
        PRECHARGE = 4'b0010,
        REFRESH   = 4'b0001,
        LOAD_MODE = 4'b0000
    } dramCmd_t;

    typedef enum logic [2:0] {
        ST_INIT,
        ST_REF1,
        ST_REF2,
        ST_MODE,
        ST_IDLE,
        ST_ACCESS
    } ioState_t;

endpackage

`default_nettype wire
